//--- all.f
+incdir+include
hdl/prefix_adder_pkg.sv
hdl/pipe_ctrl.sv
hdl/pg_gen.sv
hdl/prefix_level.sv
hdl/sum_stage.sv
hdl/prefix_adder_top.sv
bench/prefix_adder_asserts.sv
bench/tb_prefix_adder.sv

//--- Makefile
# Verilator simulation of the pipelined prefix adder.
# Any variable can be overridden, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_prefix_adder
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= STATUS: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_prefix_adder.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module tb_prefix_adder import prefix_adder_pkg::*; ();

  localparam logic [31:0] LFSR_SEED     = 32'h22f;
  localparam int          DRAIN_LIMIT   = 64;  // Cycles allowed for any wait.
  localparam int          STREAM_BEATS  = 200;
  localparam int          BUBBLE_CYCLES = 150;

  logic     clk;
  logic     rst_n;
  logic     in_valid;
  operand_t a;
  operand_t b;
  logic     cin;
  logic     out_valid;
  operand_t sum;
  logic     cout;

  logic [31:0]           lfsr_state;
  int                    cycle_cnt      = 0;
  int                    in_count       = 0;
  int                    out_count      = 0;
  int                    value_errors   = 0;  // From the directed tests.
  int                    score_errors   = 0;  // From the scoreboard.
  int                    timeout_errors = 0;
  logic [`ADDER_WIDTH:0] exp_q[$];            // Carry-out on top of the sum.
  int                    cycle_q[$];          // Cycle in which each beat was presented.

  prefix_adder_top prefix_adder_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .a         (a),
    .b         (b),
    .cin       (cin),
    .out_valid (out_valid),
    .sum       (sum),
    .cout      (cout)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random values and checks
  ////////////////////////////////////////////////////////////////////////////

  // Taps for x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input operand_t got, input operand_t expected);
    assert (got === expected) else begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      $display("** Error at %0t: %s = %b, expected %b", $time, name, got, expected);
      value_errors++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int expected);
    assert (got == expected) else begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, expected);
      value_errors++;
    end
  endtask

  task automatic report_and_finish();
    int assert_errors;
    assert_errors = prefix_adder_top_inst.prefix_adder_asserts_inst.failures;
    $display("Errors: value %0d, scoreboard %0d, timeout %0d, assertion %0d",
             value_errors, score_errors, timeout_errors, assert_errors);
    if (value_errors + score_errors + timeout_errors + assert_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  task automatic stop_on_timeout(input string what);
    timeout_errors++;
    $display("Timeout at %0t: %s", $time, what);
    report_and_finish();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////////////////////////////////////////

  // Outputs settle after the rising edge, so both sides are looked at here.
  always @(negedge clk) begin
    logic [`ADDER_WIDTH:0] expected;
    int                    due;
    if (!rst_n) begin
      exp_q.delete();  // Everything in flight is lost.
      cycle_q.delete();
    end else begin
      if (out_valid) begin
        assert (exp_q.size() != 0) else begin
          $display("Result at %0t with no beat in flight", $time);
          score_errors++;
        end
        if (exp_q.size() != 0) begin
          expected = exp_q.pop_front();
          due      = cycle_q.pop_front() + `PIPE_DEPTH;
          out_count++;
          assert (sum === expected[`ADDER_WIDTH-1:0]) else begin
            $display("** Error at %0t: sum = %h, expected %h",
                     $time, sum, expected[`ADDER_WIDTH-1:0]);
            score_errors++;
          end
          assert (cout === expected[`ADDER_WIDTH]) else begin
            $display("** Error at %0t: cout = %b, expected %b",
                     $time, cout, expected[`ADDER_WIDTH]);
            score_errors++;
          end
          assert (cycle_cnt == due) else begin
            $display("Result at %0t came in cycle %0d but was due in cycle %0d",
                     $time, cycle_cnt, due);
            score_errors++;
          end
        end
      end else if (cycle_q.size() != 0) begin
        assert (cycle_q[0] + `PIPE_DEPTH > cycle_cnt) else begin
          $display("No result at %0t for the beat of cycle %0d", $time, cycle_q[0]);
          score_errors++;
          void'(exp_q.pop_front());
          void'(cycle_q.pop_front());
        end
      end
      if (in_valid) begin
        exp_q.push_back({1'b0, a} + {1'b0, b} + {{`ADDER_WIDTH{1'b0}}, cin});
        cycle_q.push_back(cycle_cnt);
        in_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_beat(input operand_t va, input operand_t vb, input logic vc);
    @(posedge clk);
    in_valid <= 1'b1;
    a        <= va;
    b        <= vb;
    cin      <= vc;
  endtask

  task automatic drive_idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drive_random_beat();
    operand_t    va;
    operand_t    vb;
    logic [31:0] vc;
    va = random_bits(`ADDER_WIDTH);
    vb = random_bits(`ADDER_WIDTH);
    vc = random_bits(1);
    drive_beat(va, vb, vc[0]);
  endtask

  task automatic wait_for_drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      stop_on_timeout("pipeline did not drain");
    end
  endtask

  task automatic check_outputs_cleared();
    check_word("sum", sum, '0);
    check_bit("cout", cout, 1'b0);
  endtask

  // One beat on its own, timed from the cycle it is presented in.
  task automatic single_beat(input operand_t va, input operand_t vb, input logic vc);
    logic [`ADDER_WIDTH:0] expected;
    int                    waited;
    expected = {1'b0, va} + {1'b0, vb} + {{`ADDER_WIDTH{1'b0}}, vc};
    drive_beat(va, vb, vc);
    drive_idle(1);
    waited = 1;
    @(negedge clk);
    while (!out_valid && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!out_valid) begin
      stop_on_timeout("single beat never came out");
    end else begin
      check_count("latency", waited, `PIPE_DEPTH);
      check_word("sum", sum, expected[`ADDER_WIDTH-1:0]);
      check_bit("cout", cout, expected[`ADDER_WIDTH]);
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);  // One cycle per beat.
      wait_for_drain();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    int waited;
    repeat (8) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_outputs_cleared();
    end
    drive_beat(32'h0000_00ff, 32'h0000_0001, 1'b0);
    drive_idle(1);
    waited = 0;
    @(negedge clk);
    while (!out_valid && waited < DRAIN_LIMIT) begin
      check_outputs_cleared();
      @(negedge clk);
      waited++;
    end
    if (!out_valid) begin
      stop_on_timeout("first result never came out");
    end else begin
      wait_for_drain();
    end
  endtask

  task automatic test_carry_corners();
    single_beat('1, '0, 1'b1);  // Carry ripples through every bit.
    single_beat('1, '1, 1'b0);
    single_beat('1, '1, 1'b1);
    single_beat('0, '0, 1'b1);
    single_beat({(`ADDER_WIDTH/2){2'b10}}, {(`ADDER_WIDTH/2){2'b01}}, 1'b1);
    single_beat({(`ADDER_WIDTH/2){2'b01}}, {(`ADDER_WIDTH/2){2'b01}}, 1'b0);
  endtask

  task automatic test_random_stream();
    int in_start;
    int out_start;
    in_start  = in_count;
    out_start = out_count;
    repeat (STREAM_BEATS) drive_random_beat();
    drive_idle(1);
    wait_for_drain();
    check_count("beats out", out_count - out_start, in_count - in_start);
  endtask

  task automatic test_bubble_stream();
    logic        in_hist[$];
    logic        out_hist[$];
    logic [31:0] r;
    logic        expected;
    for (int i = 0; i < BUBBLE_CYCLES + `PIPE_DEPTH; i++) begin
      r = random_bits(2);
      if (i < BUBBLE_CYCLES && r[1:0] != 2'b00) begin
        drive_random_beat();
      end else begin
        drive_idle(1);
      end
      @(negedge clk);
      in_hist.push_back(in_valid);
      out_hist.push_back(out_valid);
    end
    // The pipeline was empty on entry.
    for (int i = 0; i < out_hist.size(); i++) begin
      expected = (i < `PIPE_DEPTH) ? 1'b0 : in_hist[i-`PIPE_DEPTH];
      check_bit("out_valid", out_hist[i], expected);
    end
    wait_for_drain();
  endtask

  task automatic test_reset_midstream();
    int out_start;
    repeat (20) drive_random_beat();
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b1);
    @(posedge clk);
    rst_n    <= 1'b0;
    in_valid <= 1'b0;
    @(negedge clk);
    check_bit("out_valid", out_valid, 1'b0);
    check_outputs_cleared();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    out_start = out_count;
    repeat (`PIPE_DEPTH + 3) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);  // Nothing from before the reset.
    end
    single_beat(32'h89ab_cdef, 32'h7654_3211, 1'b1);
    check_count("beats out", out_count - out_start, 1);
  endtask

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    a          = '0;
    b          = '0;
    cin        = 1'b0;
    lfsr_state = LFSR_SEED;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_carry_corners();
    test_random_stream();
    test_bubble_stream();
    test_reset_midstream();
    report_and_finish();
  end

endmodule

//--- bench/prefix_adder_asserts.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module prefix_adder_asserts import prefix_adder_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input logic     in_valid,
  input logic     out_valid,
  input operand_t sum,
  input logic     cout
);

  int settle_cnt;    // Cycles since reset, saturating at the pipeline depth.
  int failures = 0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      settle_cnt <= 0;
    end else if (settle_cnt < `PIPE_DEPTH) begin
      settle_cnt <= settle_cnt + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Valid timing
  ////////////////////////////////////////////////////////////////////////////

  valid_delay_a : assert property (@(posedge clk) disable iff (!rst_n)
    (settle_cnt == `PIPE_DEPTH) |-> (out_valid == $past(in_valid, `PIPE_DEPTH)))
  else begin
    failures++;
    $error("out_valid is not in_valid delayed by the pipeline depth");
  end

  // Beats taken before a reset must never come out after it.
  settle_a : assert property (@(posedge clk) disable iff (!rst_n)
    (settle_cnt < `PIPE_DEPTH) |-> !out_valid)
  else begin
    failures++;
    $error("out_valid high before the pipeline refilled after reset");
  end

  reset_a : assert property (@(posedge clk) !rst_n |-> !out_valid)
  else begin
    failures++;
    $error("out_valid high during reset");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result data
  ////////////////////////////////////////////////////////////////////////////

  known_a : assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown({sum, cout}))
  else begin
    failures++;
    $error("sum or cout unknown while out_valid is high");
  end

endmodule

bind prefix_adder_top prefix_adder_asserts prefix_adder_asserts_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .sum       (sum),
  .cout      (cout)
);

//--- hdl/prefix_adder_top.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module prefix_adder_top import prefix_adder_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_valid,
  input  operand_t a,
  input  operand_t b,
  input  logic     cin,
  output logic     out_valid,
  output operand_t sum,
  output logic     cout
);

  stage_en_t stage_en;

  // Index 0 is driven by pg_gen, index n+1 by prefix level n.
  operand_t g_chain   [`PREFIX_LEVELS+1];
  operand_t p_chain   [`PREFIX_LEVELS+1];
  operand_t hs_chain  [`PREFIX_LEVELS+1];
  logic     cin_chain [`PREFIX_LEVELS+1];

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline control
  ////////////////////////////////////////////////////////////////////////////

  pipe_ctrl pipe_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .stage_en  (stage_en),
    .out_valid (out_valid)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  pg_gen pg_gen_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .en      (stage_en[0]),
    .a       (a),
    .b       (b),
    .cin     (cin),
    .g_out   (g_chain[0]),
    .p_out   (p_chain[0]),
    .hs_out  (hs_chain[0]),
    .cin_out (cin_chain[0])
  );

  for (genvar lvl = 0; lvl < `PREFIX_LEVELS; lvl++) begin : g_level
    prefix_level #(
      .LEVEL (lvl)
    ) prefix_level_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (stage_en[lvl+1]),
      .g_in    (g_chain[lvl]),
      .p_in    (p_chain[lvl]),
      .hs_in   (hs_chain[lvl]),
      .cin_in  (cin_chain[lvl]),
      .g_out   (g_chain[lvl+1]),
      .p_out   (p_chain[lvl+1]),
      .hs_out  (hs_chain[lvl+1]),
      .cin_out (cin_chain[lvl+1])
    );
  end

  // Group propagates are spent by the last level.
  sum_stage sum_stage_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .en     (stage_en[`PIPE_DEPTH-1]),
    .g_in   (g_chain[`PREFIX_LEVELS]),
    .hs_in  (hs_chain[`PREFIX_LEVELS]),
    .cin_in (cin_chain[`PREFIX_LEVELS]),
    .sum    (sum),
    .cout   (cout)
  );

endmodule

//--- hdl/sum_stage.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module sum_stage import prefix_adder_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  operand_t g_in,
  input  operand_t hs_in,
  input  logic     cin_in,
  output operand_t sum,
  output logic     cout
);

  operand_t carry;
  operand_t sum_nxt;

  // Carry into bit i is the group generate of bits i-1 down to 0.
  assign carry   = {g_in[`ADDER_WIDTH-2:0], cin_in};
  assign sum_nxt = hs_in ^ carry;

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum  <= '0;
      cout <= 1'b0;
    end else if (en) begin
      sum  <= sum_nxt;
      cout <= g_in[`ADDER_WIDTH-1];  // Top group spans the whole word.
    end
  end

endmodule

//--- hdl/prefix_level.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module prefix_level import prefix_adder_pkg::*; #(
  parameter int LEVEL = 0
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  operand_t g_in,
  input  operand_t p_in,
  input  operand_t hs_in,
  input  logic     cin_in,
  output operand_t g_out,
  output operand_t p_out,
  output operand_t hs_out,
  output logic     cin_out
);

  localparam int SPAN  = 1 << LEVEL;  // Group span held in each bit on entry.
  localparam int BLOCK = 2 * SPAN;    // Group span held in each bit on exit.

  operand_t g_nxt;
  operand_t p_nxt;

  ////////////////////////////////////////////////////////////////////////////
  // Sklansky combine
  ////////////////////////////////////////////////////////////////////////////

  // Blocks of BLOCK bits are split in two halves. Every bit of the upper
  // half takes in the group of the top bit of the lower half, so its span
  // doubles. Lower half bits already cover their whole span and pass.
  for (genvar i = 0; i < `ADDER_WIDTH; i++) begin : g_bit
    if (((i / SPAN) % 2) == 1) begin : g_merge
      localparam int J = (i / BLOCK) * BLOCK + SPAN - 1;  // Lower half top bit.

      assign g_nxt[i] = g_in[i] | (p_in[i] & g_in[J]);
      assign p_nxt[i] = p_in[i] & p_in[J];
    end else begin : g_pass
      assign g_nxt[i] = g_in[i];
      assign p_nxt[i] = p_in[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Level registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      g_out   <= '0;
      p_out   <= '0;
      hs_out  <= '0;
      cin_out <= 1'b0;
    end else if (en) begin
      g_out   <= g_nxt;
      p_out   <= p_nxt;
      hs_out  <= hs_in;   // Delayed alongside the groups of the same add.
      cin_out <= cin_in;  // Needed again for bit 0 of the sum.
    end
  end

endmodule

//--- hdl/pg_gen.sv
`timescale 1ns/100ps

module pg_gen import prefix_adder_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  operand_t a,
  input  operand_t b,
  input  logic     cin,
  output operand_t g_out,
  output operand_t p_out,
  output operand_t hs_out,
  output logic     cin_out
);

  operand_t g_bit;
  operand_t p_bit;
  operand_t hs_bit;

  ////////////////////////////////////////////////////////////////////////////
  // Bitwise generate and propagate
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    g_bit  = a & b;
    p_bit  = a | b;  // Transmit form; the half-sum is kept apart.
    hs_bit = a ^ b;
    // With cin folded in here, every group generate that reaches down to
    // bit 0 is the carry out of its top bit.
    g_bit[0] = g_bit[0] | (p_bit[0] & cin);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      g_out   <= '0;
      p_out   <= '0;
      hs_out  <= '0;
      cin_out <= 1'b0;
    end else if (en) begin
      g_out   <= g_bit;
      p_out   <= p_bit;
      hs_out  <= hs_bit;  // Travels with its own add.
      cin_out <= cin;
    end
  end

endmodule

//--- hdl/pipe_ctrl.sv
`timescale 1ns/100ps
`include "prefix_adder_macros.svh"

module pipe_ctrl import prefix_adder_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      in_valid,
  output stage_en_t stage_en,
  output logic      out_valid
);

  stage_en_t valid_q;  // Bit n is set while stage n holds a live item.

  ////////////////////////////////////////////////////////////////////////////
  // Load enables
  ////////////////////////////////////////////////////////////////////////////

  // Stage 0 loads straight from the input qualifier.
  // Every later stage loads when the stage in front of it holds a live item.
  assign stage_en = {valid_q[`PIPE_DEPTH-2:0], in_valid};

  ////////////////////////////////////////////////////////////////////////////
  // Valid shift register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;  // Drops everything in flight.
    end else begin
      valid_q <= stage_en;  // Bubbles shift down with the data.
    end
  end

  assign out_valid = valid_q[`PIPE_DEPTH-1];  // Qualifies the sum stage registers.

endmodule

//--- hdl/prefix_adder_pkg.sv
`include "prefix_adder_macros.svh"

package prefix_adder_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath words
  ////////////////////////////////////////////////////////////////////////////

  // Operands, sums and every generate, propagate and half-sum word.
  typedef logic [`ADDER_WIDTH-1:0] operand_t;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline control
  ////////////////////////////////////////////////////////////////////////////

  // Bit n loads pipeline register stage n.
  typedef logic [`PIPE_DEPTH-1:0] stage_en_t;

endpackage

//--- include/prefix_adder_macros.svh
`ifndef PREFIX_ADDER_MACROS_SVH
`define PREFIX_ADDER_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Adder geometry
////////////////////////////////////////////////////////////////////////////

// Operand width in bits.
`define ADDER_WIDTH 32

// One Sklansky level per doubling of the group span.
`define PREFIX_LEVELS ($clog2(`ADDER_WIDTH))

// Input to output latency in clock cycles.
`define PIPE_DEPTH (`PREFIX_LEVELS + 2)

`endif
